/* src/io_bus_defs.svh */
// io bus constants for widths, lane count and the decoded port pages
`ifndef IO_BUS_DEFS_SVH
`define IO_BUS_DEFS_SVH

// --------------------
// widths
// --------------------
`define IO_ADDR_W        16
`define IO_DATA_W        32
`define IO_BYTE_W        8
`define IO_LANES         4
// low address bits inside one port page
`define IO_OFFSET_W      4
`define IO_NUM_TARGETS   6

// --------------------
// port pages
// --------------------
// page number is the address above the offset bits
`define IO_PAGE_PIC_M    12'h002
`define IO_PAGE_PIT      12'h004
`define IO_PAGE_PS2      12'h006
`define IO_PAGE_RTC      12'h007
`define IO_PAGE_PIC_S    12'h00A
// disk data port, full word path
`define IO_PAGE_HDD      12'h01F

// ide control sits alone on a shared page
`define IO_PORT_IDE_CTRL 16'h03F6

`endif

/* src/io_bus_pkg.sv */
// io bus types for port addresses, data, target selects and request bundles
`include "io_bus_defs.svh"

package io_bus_pkg;

   // --------------------
   // plain vectors
   // --------------------
   typedef logic [`IO_ADDR_W-1:0]         io_addr_t;
   typedef logic [`IO_DATA_W-1:0]         io_word_t;
   typedef logic [`IO_BYTE_W-1:0]         io_byte_t;
   typedef logic [`IO_LANES-1:0]          io_be_t;
   typedef logic [`IO_OFFSET_W-1:0]       io_offset_t;
   typedef logic [$clog2(`IO_LANES)-1:0]  io_lane_t;
   // one bit per byte target
   typedef logic [`IO_NUM_TARGETS-1:0]    io_target_mask_t;
   typedef io_byte_t [`IO_NUM_TARGETS-1:0] io_target_rdata_t;

   // bit positions in the target masks
   typedef enum logic [2:0] {
      tgt_pic_master = 3'd0,
      tgt_pit        = 3'd1,
      tgt_ps2        = 3'd2,
      tgt_rtc        = 3'd3,
      tgt_pic_slave  = 3'd4,
      tgt_ide_ctrl   = 3'd5
   } io_target_e;

   typedef enum logic {
      conv_idle,
      conv_issue
   } conv_state_e;

   // --------------------
   // request bundles
   // --------------------
   typedef struct packed {
      io_addr_t addr;
      io_be_t   be;
      logic     read;
      logic     write;
      io_word_t wdata;
   } host_req_t;

   // single byte access out of the lane converter
   typedef struct packed {
      io_addr_t addr;
      logic     read;
      logic     write;
      io_byte_t wdata;
   } byte_req_t;

   // shared by all byte targets
   typedef struct packed {
      io_offset_t offset;
      io_byte_t   wdata;
   } target_req_t;

   typedef struct packed {
      logic     word_sel;
      logic     read;
      logic     write;
      io_word_t wdata;
      io_be_t   be;
   } hdd_req_t;

endpackage

/* src/io_host_split.sv */
// host split that steers disk page accesses to the data port and merges returns
`timescale 1ns/1ns
`include "io_bus_defs.svh"

module io_host_split (
   input  logic                  clk_sys,
   input  logic                  rst_n,
   input  io_bus_pkg::host_req_t host_req,
   input  logic                  conv_waitrequest,
   input  io_bus_pkg::io_word_t  conv_readdata,
   input  logic                  conv_readdatavalid,
   input  io_bus_pkg::io_word_t  hdd_readdata,
   output io_bus_pkg::host_req_t conv_req,
   output io_bus_pkg::hdd_req_t  hdd_req,
   output logic                  waitrequest,
   output io_bus_pkg::io_word_t  readdata,
   output logic                  readdatavalid
);
   import io_bus_pkg::*;

   logic is_hdd;
   logic hdd_rvalid;

   // --------------------
   // page check
   // --------------------
   assign is_hdd = (host_req.addr[`IO_ADDR_W-1:`IO_OFFSET_W] == `IO_PAGE_HDD);

   // full word to the disk, no splitting
   assign hdd_req.word_sel = host_req.addr[2];
   assign hdd_req.read     = host_req.read  && is_hdd;
   assign hdd_req.write    = host_req.write && is_hdd;
   assign hdd_req.wdata    = host_req.wdata;
   assign hdd_req.be       = host_req.be;

   // converter only sees the byte path
   always_comb begin
      conv_req       = host_req;
      conv_req.read  = host_req.read  && !is_hdd;
      conv_req.write = host_req.write && !is_hdd;
   end

   // disk never stalls
   assign waitrequest = conv_waitrequest;

   // --------------------
   // read return
   // --------------------
   // disk word lands one cycle after the strobe
   always_ff @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         hdd_rvalid <= 1'b0;
      end else begin
         hdd_rvalid <= hdd_req.read;
      end
   end

   // one read outstanding so the two valids never overlap
   assign readdata      = hdd_rvalid ? hdd_readdata : conv_readdata;
   assign readdatavalid = hdd_rvalid || conv_readdatavalid;

endmodule

/* src/io_byte_lane_converter.sv */
// byte lane converter that turns one word access into a run of byte accesses
`timescale 1ns/1ns
`include "io_bus_defs.svh"

module io_byte_lane_converter (
   input  logic                  clk_sys,
   input  logic                  rst_n,
   input  io_bus_pkg::host_req_t conv_req,
   input  logic                  byte_rvalid,
   input  io_bus_pkg::io_byte_t  byte_rdata,
   output logic                  conv_waitrequest,
   output io_bus_pkg::byte_req_t byte_req,
   output io_bus_pkg::io_word_t  conv_readdata,
   output logic                  conv_readdatavalid
);
   import io_bus_pkg::*;

   // lowest set lane of a mask
   function automatic io_lane_t lowest_lane(input io_be_t mask);
      io_lane_t lane;
      lane = '0;
      for (int i = `IO_LANES - 1; i >= 0; i--) begin
         if (mask[i]) begin
            lane = io_lane_t'(i);
         end
      end
      return lane;
   endfunction

   conv_state_e state;
   // be field holds the lanes still to go
   host_req_t   req_q;
   io_lane_t    lane_q;

   host_req_t   active_req;
   io_lane_t    cur_lane;
   io_be_t      rest_mask;
   logic        issue;
   logic        last;
   logic        start_read;

   // return side
   io_lane_t    tag_lane;
   logic        tag_last;
   io_word_t    rd_word;
   io_word_t    merged;

   // --------------------
   // issue side
   // --------------------
   // first byte straight from the host request, later ones from the capture
   always_comb begin
      if (state == conv_idle) begin
         active_req = conv_req;
         cur_lane   = lowest_lane(conv_req.be);
         issue      = conv_req.read || conv_req.write;
      end else begin
         active_req = req_q;
         cur_lane   = lane_q;
         issue      = 1'b1;
      end
      rest_mask = active_req.be & ~(io_be_t'(1) << cur_lane);
      last      = (rest_mask == '0);
   end

   // hold the host until the final lane goes out
   assign conv_waitrequest = issue && !last;
   assign start_read       = (state == conv_idle) && conv_req.read;

   // lane i lands on the word address plus i
   assign byte_req.addr  = {active_req.addr[`IO_ADDR_W-1:$bits(io_lane_t)], cur_lane};
   assign byte_req.read  = issue && active_req.read;
   assign byte_req.write = issue && active_req.write;
   assign byte_req.wdata = active_req.wdata[cur_lane*`IO_BYTE_W +: `IO_BYTE_W];

   // fsm
   always_ff @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         state  <= conv_idle;
         lane_q <= '0;
      end else begin
         lane_q <= lowest_lane(rest_mask);
         case (state)
            conv_idle: begin
               if (issue && !last) begin
                  state <= conv_issue;
               end
            end
            conv_issue: begin
               if (last) begin
                  state <= conv_idle;
               end
            end
            default: state <= conv_idle;
         endcase
      end
   end

   // capture while idle, then only the lane mask moves
   always_ff @(posedge clk_sys) begin
      if (state == conv_idle) begin
         req_q <= conv_req;
      end
      req_q.be <= rest_mask;
   end

   // --------------------
   // return side
   // --------------------
   // tag follows the strobe by one cycle like the data
   always_ff @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         tag_lane <= '0;
         tag_last <= 1'b0;
      end else begin
         tag_lane <= cur_lane;
         tag_last <= last;
      end
   end

   // drop the incoming byte into its lane
   always_comb begin
      for (int i = 0; i < `IO_LANES; i++) begin
         if (byte_rvalid && (tag_lane == io_lane_t'(i))) begin
            merged[i*`IO_BYTE_W +: `IO_BYTE_W] = byte_rdata;
         end else begin
            merged[i*`IO_BYTE_W +: `IO_BYTE_W] = rd_word[i*`IO_BYTE_W +: `IO_BYTE_W];
         end
      end
   end

   // cleared on a new read so unenabled lanes stay zero
   always_ff @(posedge clk_sys) begin
      if (start_read) begin
         rd_word <= '0;
      end else if (byte_rvalid) begin
         rd_word <= merged;
      end
   end

   // word complete with the last lane's byte
   assign conv_readdata      = merged;
   assign conv_readdatavalid = byte_rvalid && tag_last;

endmodule

/* src/io_port_decoder.sv */
// port decoder that maps byte accesses onto target strobes and returns read bytes
`timescale 1ns/1ns
`include "io_bus_defs.svh"

module io_port_decoder (
   input  logic                         clk_sys,
   input  logic                         rst_n,
   input  io_bus_pkg::byte_req_t        byte_req,
   input  io_bus_pkg::io_target_rdata_t target_readdata,
   output io_bus_pkg::target_req_t      target_req,
   output io_bus_pkg::io_target_mask_t  target_read,
   output io_bus_pkg::io_target_mask_t  target_write,
   output logic                         byte_rvalid,
   output io_bus_pkg::io_byte_t         byte_rdata
);
   import io_bus_pkg::*;

   logic [`IO_ADDR_W-`IO_OFFSET_W-1:0] page;
   io_target_mask_t                    hit;
   logic                               unmapped_rd;
   // top bit marks an unmapped read
   logic [`IO_NUM_TARGETS:0]           rd_sel_q;

   // --------------------
   // address decode
   // --------------------
   assign page = byte_req.addr[`IO_ADDR_W-1:`IO_OFFSET_W];

   // pages are disjoint, at most one hit
   always_comb begin
      hit                 = '0;
      hit[tgt_pic_master] = (page == `IO_PAGE_PIC_M);
      hit[tgt_pit]        = (page == `IO_PAGE_PIT);
      hit[tgt_ps2]        = (page == `IO_PAGE_PS2);
      hit[tgt_rtc]        = (page == `IO_PAGE_RTC);
      hit[tgt_pic_slave]  = (page == `IO_PAGE_PIC_S);
      // single port, full compare
      hit[tgt_ide_ctrl]   = (byte_req.addr == `IO_PORT_IDE_CTRL);
   end

   // strobes same cycle as the byte request
   assign target_read  = hit & {`IO_NUM_TARGETS{byte_req.read}};
   assign target_write = hit & {`IO_NUM_TARGETS{byte_req.write}};

   // offset and data broadcast to everyone
   assign target_req.offset = byte_req.addr[`IO_OFFSET_W-1:0];
   assign target_req.wdata  = byte_req.wdata;

   // unmapped writes just vanish
   assign unmapped_rd = byte_req.read && (hit == '0);

   // --------------------
   // read return
   // --------------------
   always_ff @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         rd_sel_q <= '0;
      end else begin
         rd_sel_q <= {unmapped_rd, target_read};
      end
   end

   assign byte_rvalid = |rd_sel_q;

   // and-or mux over the one-hot select
   // unmapped bit picks nothing so the byte reads zero
   always_comb begin
      byte_rdata = '0;
      for (int i = 0; i < `IO_NUM_TARGETS; i++) begin
         if (rd_sel_q[i]) begin
            byte_rdata = byte_rdata | target_readdata[i];
         end
      end
   end

endmodule

/* src/io_bus_top.sv */
// io port bus top joining the disk split, byte lane converter and port decoder
`timescale 1ns/1ns

module io_bus_top (
   input  logic                         clk_sys,
   input  logic                         rst_n,
   // host port access
   input  io_bus_pkg::host_req_t        host_req,
   output logic                         waitrequest,
   output io_bus_pkg::io_word_t         readdata,
   output logic                         readdatavalid,
   // disk data port
   output io_bus_pkg::hdd_req_t         hdd_req,
   input  io_bus_pkg::io_word_t         hdd_readdata,
   // byte targets
   output io_bus_pkg::target_req_t      target_req,
   output io_bus_pkg::io_target_mask_t  target_read,
   output io_bus_pkg::io_target_mask_t  target_write,
   input  io_bus_pkg::io_target_rdata_t target_readdata
);
   import io_bus_pkg::*;

   // --------------------
   // internal links
   // --------------------
   // split to converter
   host_req_t conv_req;
   logic      conv_waitrequest;
   io_word_t  conv_readdata;
   logic      conv_readdatavalid;

   // converter to decoder
   byte_req_t byte_req;
   logic      byte_rvalid;
   io_byte_t  byte_rdata;

   // disk page goes straight out, the rest to the converter
   io_host_split i_io_host_split (
      .clk_sys            (clk_sys),
      .rst_n              (rst_n),
      .host_req           (host_req),
      .conv_waitrequest   (conv_waitrequest),
      .conv_readdata      (conv_readdata),
      .conv_readdatavalid (conv_readdatavalid),
      .hdd_readdata       (hdd_readdata),
      .conv_req           (conv_req),
      .hdd_req            (hdd_req),
      .waitrequest        (waitrequest),
      .readdata           (readdata),
      .readdatavalid      (readdatavalid)
   );

   // word to byte sequencing
   io_byte_lane_converter i_io_byte_lane_converter (
      .clk_sys            (clk_sys),
      .rst_n              (rst_n),
      .conv_req           (conv_req),
      .byte_rvalid        (byte_rvalid),
      .byte_rdata         (byte_rdata),
      .conv_waitrequest   (conv_waitrequest),
      .byte_req           (byte_req),
      .conv_readdata      (conv_readdata),
      .conv_readdatavalid (conv_readdatavalid)
   );

   // byte address to target strobes
   io_port_decoder i_io_port_decoder (
      .clk_sys         (clk_sys),
      .rst_n           (rst_n),
      .byte_req        (byte_req),
      .target_readdata (target_readdata),
      .target_req      (target_req),
      .target_read     (target_read),
      .target_write    (target_write),
      .byte_rvalid     (byte_rvalid),
      .byte_rdata      (byte_rdata)
   );

endmodule

/* tests/io_bus_assertions.sv */
// protocol assertions for the io port bus, bound to the top level
`timescale 1ns/1ns

module io_bus_assertions (
   input logic                        clk_sys,
   input logic                        rst_n,
   input io_bus_pkg::host_req_t       host_req,
   input io_bus_pkg::host_req_t       conv_req,
   input logic                        waitrequest,
   input logic                        readdatavalid,
   input io_bus_pkg::io_target_mask_t target_read,
   input io_bus_pkg::io_target_mask_t target_write
);
   int unsigned fail_count = 0;
   // host read taken and not yet answered
   logic        rd_pending;

   always_ff @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         rd_pending <= 1'b0;
      end else if (host_req.read && !waitrequest) begin
         rd_pending <= 1'b1;
      end else if (readdatavalid) begin
         rd_pending <= 1'b0;
      end
   end

   // --------------------
   // properties
   // --------------------
   wait_has_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
      waitrequest |-> (host_req.read || host_req.write))
   else begin
      $error("waitrequest high with no host request");
      fail_count++;
   end

   // pages are disjoint so one strobe at most
   one_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
      $onehot0({target_read, target_write}))
   else begin
      $error("more than one target strobe in a cycle");
      fail_count++;
   end

   valid_has_read: assert property (@(posedge clk_sys) disable iff (!rst_n)
      readdatavalid |-> rd_pending)
   else begin
      $error("readdatavalid with no read outstanding");
      fail_count++;
   end

   be_nonzero: assert property (@(posedge clk_sys) disable iff (!rst_n)
      ((conv_req.read || conv_req.write) && !waitrequest) |-> (conv_req.be != '0))
   else begin
      $error("byte path request taken with an empty byte enable");
      fail_count++;
   end

endmodule

bind io_bus_top io_bus_assertions i_io_bus_assertions (
   .clk_sys       (clk_sys),
   .rst_n         (rst_n),
   .host_req      (host_req),
   .conv_req      (conv_req),
   .waitrequest   (waitrequest),
   .readdatavalid (readdatavalid),
   .target_read   (target_read),
   .target_write  (target_write)
);

/* tests/io_bus_tb.sv */
// io bus testbench with peripheral models, a reference model and random accesses
`timescale 1ns/1ns
`include "io_bus_defs.svh"

module io_bus_tb;
   import io_bus_pkg::*;

   localparam int TIMEOUT = 40;

   logic             clk_sys = 1'b0;
   logic             rst_n = 1'b0;
   host_req_t        host_req = '0;
   logic             waitrequest;
   io_word_t         readdata;
   logic             readdatavalid;
   hdd_req_t         hdd_req;
   io_word_t         hdd_readdata = '0;
   target_req_t      target_req;
   io_target_mask_t  target_read;
   io_target_mask_t  target_write;
   io_target_rdata_t target_readdata = '0;
   // peripheral contents and the reference copies
   io_byte_t         tgt_mem [`IO_NUM_TARGETS][2**`IO_OFFSET_W];
   io_byte_t         ref_tgt [`IO_NUM_TARGETS][2**`IO_OFFSET_W];
   io_word_t         hdd_mem [2];
   io_word_t         ref_hdd [2];
   // dropped video and system control pages
   logic [11:0]      dropped [4] = '{12'h03B, 12'h03C, 12'h03D, 12'h009};

   io_bus_top i_io_bus_top (.*);

   always #4 clk_sys = ~clk_sys;

   // fill pattern from target and offset together
   function automatic io_byte_t fill_byte(input int t, input int off);
      return io_byte_t'((t * 16 + off) * 37 + 11);
   endfunction

   function automatic io_word_t fill_word(input int w);
      return io_word_t'(32'hd15c_0a55 ^ (w * 32'h0013_5793));
   endfunction

   // --------------------
   // peripheral models
   // --------------------
   // read data shows up one cycle after the strobe
   always @(posedge clk_sys or negedge rst_n) begin
      if (!rst_n) begin
         for (int t = 0; t < `IO_NUM_TARGETS; t++) begin
            for (int o = 0; o < 2**`IO_OFFSET_W; o++) begin
               tgt_mem[t][o] <= fill_byte(t, o);
            end
         end
         hdd_mem[0] <= fill_word(0);
         hdd_mem[1] <= fill_word(1);
      end else begin
         for (int t = 0; t < `IO_NUM_TARGETS; t++) begin
            if (target_write[t]) begin
               tgt_mem[t][target_req.offset] <= target_req.wdata;
            end
            if (target_read[t]) begin
               target_readdata[t] <= tgt_mem[t][target_req.offset];
            end
         end
         if (hdd_req.read) begin
            hdd_readdata <= hdd_mem[hdd_req.word_sel];
         end
         for (int i = 0; i < `IO_LANES; i++) begin
            if (hdd_req.write && hdd_req.be[i]) begin
               hdd_mem[hdd_req.word_sel][i*8 +: 8] <= hdd_req.wdata[i*8 +: 8];
            end
         end
      end
   end

   // --------------------
   // reference model
   // --------------------
   // target index of one byte port, -1 when unmapped
   function automatic int target_of(input io_addr_t a);
      if (a == `IO_PORT_IDE_CTRL) begin
         return int'(tgt_ide_ctrl);
      end
      case (a[`IO_ADDR_W-1:`IO_OFFSET_W])
         `IO_PAGE_PIC_M: return int'(tgt_pic_master);
         `IO_PAGE_PIT:   return int'(tgt_pit);
         `IO_PAGE_PS2:   return int'(tgt_ps2);
         `IO_PAGE_RTC:   return int'(tgt_rtc);
         `IO_PAGE_PIC_S: return int'(tgt_pic_slave);
         default:        return -1;
      endcase
   endfunction

   function automatic io_addr_t target_port(input int t, input io_offset_t off);
      case (t)
         0:       return {`IO_PAGE_PIC_M, off};
         1:       return {`IO_PAGE_PIT, off};
         2:       return {`IO_PAGE_PS2, off};
         3:       return {`IO_PAGE_RTC, off};
         4:       return {`IO_PAGE_PIC_S, off};
         default: return `IO_PORT_IDE_CTRL;
      endcase
   endfunction

   // --------------------
   // checks
   // --------------------
   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_mask(input string name, input io_target_mask_t got,
                             input io_target_mask_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_hdd(input string name, input hdd_req_t got, input hdd_req_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_target(input string name, input target_req_t got,
                               input target_req_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // one host access with every response checked against the model
   task automatic checked_access(input io_addr_t addr, input io_be_t be, input logic rd,
                                 input io_word_t wdata);
      io_word_t        exp_word;
      io_word_t        got_word;
      io_target_mask_t exp_mask;
      io_target_mask_t seen_rd;
      io_target_mask_t seen_wr;
      hdd_req_t        exp_hdd;
      hdd_req_t        hdd_seen;
      target_req_t     exp_treq;
      io_lane_t        lane_seq [`IO_LANES];
      io_addr_t        a;
      logic            is_hdd;
      logic            accepted;
      int              t;
      int              n_lanes;
      int              exp_strobes;
      int              strobes;
      int              waits;
      int              rv_cycle;
      int              cyc;
      is_hdd      = (addr[`IO_ADDR_W-1:`IO_OFFSET_W] == `IO_PAGE_HDD);
      exp_word    = '0;
      got_word    = '0;
      exp_mask    = '0;
      exp_strobes = 0;
      n_lanes     = 0;
      // enabled lanes in the order they go out
      for (int i = 0; i < `IO_LANES; i++) begin
         if (be[i]) begin
            lane_seq[n_lanes] = io_lane_t'(i);
            n_lanes++;
         end
      end
      if (is_hdd) begin
         exp_word = ref_hdd[addr[2]];
         for (int i = 0; i < `IO_LANES; i++) begin
            if (!rd && be[i]) begin
               ref_hdd[addr[2]][i*8 +: 8] = wdata[i*8 +: 8];
            end
         end
      end else begin
         // lane i goes to the word address plus i
         for (int i = 0; i < `IO_LANES; i++) begin
            a = {addr[`IO_ADDR_W-1:2], 2'(i)};
            t = target_of(a);
            if (be[i] && t >= 0) begin
               exp_mask[t] = 1'b1;
               exp_strobes++;
               if (rd) begin
                  exp_word[i*8 +: 8] = ref_tgt[t][a[`IO_OFFSET_W-1:0]];
               end else begin
                  ref_tgt[t][a[`IO_OFFSET_W-1:0]] = wdata[i*8 +: 8];
               end
            end
         end
      end
      exp_hdd = '{word_sel: addr[2], read: rd, write: !rd, wdata: wdata, be: be};

      @(posedge clk_sys);
      #1;
      host_req = '{addr: addr, be: be, read: rd, write: !rd, wdata: wdata};
      accepted = 1'b0;
      seen_rd  = '0;
      seen_wr  = '0;
      hdd_seen = '0;
      strobes  = 0;
      waits    = 0;
      rv_cycle = -1;
      cyc      = 0;
      // cycle 0 is the cycle the request appears
      while (!accepted || (rd && rv_cycle < 0)) begin
         @(negedge clk_sys);
         if (cyc == 0) begin
            hdd_seen = hdd_req;
         end
         seen_rd = seen_rd | target_read;
         seen_wr = seen_wr | target_write;
         strobes += $countones({target_read, target_write});
         // write strobe in cycle c carries the c-th enabled lane
         if (target_write != '0 && cyc < n_lanes) begin
            exp_treq.offset = {addr[`IO_OFFSET_W-1:2], lane_seq[cyc]};
            exp_treq.wdata  = wdata[int'(lane_seq[cyc])*8 +: 8];
            check_target("target_req", target_req, exp_treq);
         end
         if (readdatavalid) begin
            rv_cycle = cyc;
            got_word = readdata;
         end
         if (!accepted && waitrequest) begin
            waits++;
         end else begin
            accepted = 1'b1;
         end
         cyc++;
         if (cyc > TIMEOUT) begin
            stop_on_error("timed out waiting for the DUT to take or answer an access");
         end
         @(posedge clk_sys);
         #1;
         if (accepted) begin
            host_req.read  = 1'b0;
            host_req.write = 1'b0;
         end
      end

      if (rd) begin
         check_word("readdata", got_word, exp_word);
      end
      check_mask("target_read", seen_rd, rd ? exp_mask : '0);
      check_mask("target_write", seen_wr, rd ? '0 : exp_mask);
      check_count("target strobe count", strobes, exp_strobes);
      check_count("waitrequest cycles", waits, is_hdd ? 0 : $countones(be) - 1);
      check_count("readdatavalid cycle", rv_cycle, !rd ? -1 : (is_hdd ? 1 : $countones(be)));
      if (is_hdd) begin
         check_hdd("hdd_req", hdd_seen, exp_hdd);
      end else begin
         check_count("hdd strobes", int'({hdd_seen.read, hdd_seen.write}), 0);
      end
   endtask

   // --------------------
   // stimulus
   // --------------------
   initial begin
      io_addr_t a;
      io_be_t   be;
      int       kind;
      void'($urandom(32'hf5fb5c53));
      for (int t = 0; t < `IO_NUM_TARGETS; t++) begin
         for (int o = 0; o < 2**`IO_OFFSET_W; o++) begin
            ref_tgt[t][o] = fill_byte(t, o);
         end
      end
      ref_hdd[0] = fill_word(0);
      ref_hdd[1] = fill_word(1);
      repeat (3) @(posedge clk_sys);
      #1;
      rst_n = 1'b1;

      // quiet bus straight after reset
      @(negedge clk_sys);
      check_count("waitrequest", int'(waitrequest), 0);
      check_count("readdatavalid", int'(readdatavalid), 0);
      check_mask("target strobes", target_read | target_write, '0);
      check_count("hdd strobes", int'({hdd_req.read, hdd_req.write}), 0);

      // single lane write and read back on each target
      for (int t = 0; t < `IO_NUM_TARGETS; t++) begin
         a  = target_port(t, io_offset_t'($urandom));
         be = io_be_t'(1) << a[1:0];
         checked_access(a, be, 1'b0, $urandom);
         checked_access(a, be, 1'b1, $urandom);
      end

      // multi lane reads
      for (int i = 0; i < 40; i++) begin
         a = target_port(int'($urandom_range(5, 0)), io_offset_t'($urandom));
         checked_access(a, io_be_t'($urandom_range(15, 1)), 1'b1, $urandom);
      end

      // disk page, alternating write and read
      for (int i = 0; i < 16; i++) begin
         a = {`IO_PAGE_HDD, io_offset_t'($urandom)};
         checked_access(a, io_be_t'($urandom_range(15, 1)), i[0], $urandom);
      end

      // unmapped pages drop writes and read zero
      for (int i = 0; i < 16; i++) begin
         a = {dropped[i % 4], io_offset_t'($urandom)};
         checked_access(a, io_be_t'($urandom_range(15, 1)), i[0], $urandom);
      end

      // mixed run weighted toward mapped ports
      for (int i = 0; i < 400; i++) begin
         kind = int'($urandom_range(99, 0));
         if (kind < 70) begin
            a = target_port(int'($urandom_range(5, 0)), io_offset_t'($urandom));
         end else if (kind < 85) begin
            a = {`IO_PAGE_HDD, io_offset_t'($urandom)};
         end else begin
            a = {dropped[$urandom_range(3, 0)], io_offset_t'($urandom)};
         end
         checked_access(a, io_be_t'($urandom_range(15, 1)), 1'($urandom_range(1, 0)),
                        $urandom);
      end

      if (i_io_bus_top.i_io_bus_assertions.fail_count != 0) begin
         stop_on_error("a protocol assertion failed during the run");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

/* io_bus.f */
+incdir+src
src/io_bus_pkg.sv
src/io_host_split.sv
src/io_byte_lane_converter.sv
src/io_port_decoder.sv
src/io_bus_top.sv
tests/io_bus_assertions.sv
tests/io_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the io bus testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module io_bus_tb \
   -f io_bus.f -o io_bus_sim > sim.log 2>&1 \
   && ./obj_dir/io_bus_sim +verilator+error+limit+100 >> sim.log 2>&1
grep -qx "Verification passed" sim.log && echo "simulation passed, see sim.log" \
   || { echo "simulation failed, see sim.log"; exit 1; }
